// ==== spi_pkg.sv ====
// ----------------------------------------------------------------------
// SPI register bridge package
// Frame layout, opcode and status encodings shared by the design
// ----------------------------------------------------------------------
`default_nettype none

package spi_pkg;

  // Frame geometry
  localparam int FRAME_BITS = 16;
  localparam int OP_MSB     = 15;
  localparam int OP_LSB     = 14;
  localparam int PAR_BIT    = 13;
  localparam int ADDR_MSB   = 12;
  localparam int ADDR_LSB   = 8;
  localparam int DATA_BITS  = 8;
  localparam int NUM_REGS   = 32;

  // One SPI frame, MSB shifted first
  typedef logic [FRAME_BITS-1:0] frame_t;

  // Command opcode in bits 15:14 of a host frame
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2,
    OP_RSVD  = 2'd3
  } opcode_t;

  // Status in bits 15:14 of a reply frame
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ACK   = 2'd1,
    ST_PERR  = 2'd2,
    ST_BADOP = 2'd3
  } status_t;

endpackage

`default_nettype wire

// ==== spi_frame_if.sv ====
// ----------------------------------------------------------------------
// Push/pull frame interface between SPI minion and register bridge
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface spi_frame_if;
  import spi_pkg::*;

  logic   push_en;
  frame_t push_msg;
  logic   parity;
  logic   pull_en;
  frame_t pull_msg;

  modport minion (output push_en, push_msg, parity, pull_en, input pull_msg);
  modport bridge (input push_en, push_msg, parity, pull_en, output pull_msg);

endinterface

`default_nettype wire

// ==== spi_synchronizer.sv ====
// ----------------------------------------------------------------------
// Two-flop synchronizer for one asynchronous SPI pin
// Gives the synchronized level plus one-cycle edge pulses
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spi_synchronizer #(
  parameter logic idle_level = 1'b0
) (
  input  logic clk,
  input  logic rst,
  input  logic in_,
  output logic out,
  output logic posedge_,
  output logic negedge_
);

  logic sync_q1;
  logic sync_q2;
  logic prev_q;

  // All stages start at the idle level so reset gives no edge
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q1 <= idle_level;
      sync_q2 <= idle_level;
      prev_q  <= idle_level;
    end else begin
      sync_q1 <= in_;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  assign out      = sync_q2;
  assign posedge_ = sync_q2 & ~prev_q;
  assign negedge_ = ~sync_q2 & prev_q;

endmodule

`default_nettype wire

// ==== spi_shift_reg.sv ====
// ----------------------------------------------------------------------
// Frame-wide shift register, MSB first
// Parallel load wins over an enabled one-bit shift
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spi_shift_reg (
  input  logic            clk,
  input  logic            rst,
  input  logic            d,
  input  logic            en,
  input  logic            load_en,
  input  spi_pkg::frame_t load,
  output spi_pkg::frame_t q
);
  import spi_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (load_en) begin
      q <= load;
    end else if (en) begin
      // New bit enters at the LSB
      q <= {q[FRAME_BITS-2:0], d};
    end
  end

endmodule

`default_nettype wire

// ==== spi_minion.sv ====
// ----------------------------------------------------------------------
// SPI mode 0 minion
// Shifts one frame in and one out, pushes on cs rise, pulls on cs fall
// and flags odd parity over the lower 14 bits of the pushed frame
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spi_minion (
  input  logic              clk,
  input  logic              rst,
  input  logic              cs,
  input  logic              sclk,
  input  logic              mosi,
  output logic              miso,
  spi_frame_if.minion       frame
);
  import spi_pkg::*;

  logic   cs_level;
  logic   cs_rise;
  logic   cs_fall;
  logic   sclk_rise;
  logic   sclk_fall;
  logic   mosi_level;
  logic   shift_in_en;
  logic   shift_out_en;
  frame_t in_q;
  frame_t out_q;

  // --------------------------------------------------------------------
  // Pin synchronizers
  // --------------------------------------------------------------------

  // Chip select idles high
  spi_synchronizer #(.idle_level(1'b1)) cs_sync (
    .clk      (clk),
    .rst      (rst),
    .in_      (cs),
    .out      (cs_level),
    .posedge_ (cs_rise),
    .negedge_ (cs_fall)
  );

  spi_synchronizer #(.idle_level(1'b0)) sclk_sync (
    .clk      (clk),
    .rst      (rst),
    .in_      (sclk),
    .out      (),
    .posedge_ (sclk_rise),
    .negedge_ (sclk_fall)
  );

  spi_synchronizer #(.idle_level(1'b0)) mosi_sync (
    .clk      (clk),
    .rst      (rst),
    .in_      (mosi),
    .out      (mosi_level),
    .posedge_ (),
    .negedge_ ()
  );

  // --------------------------------------------------------------------
  // Frame shifters
  // --------------------------------------------------------------------

  // Sample on sclk rise, launch on sclk fall
  assign shift_in_en  = ~cs_level & sclk_rise;
  assign shift_out_en = ~cs_level & sclk_fall;

  spi_shift_reg shreg_in (
    .clk     (clk),
    .rst     (rst),
    .d       (mosi_level),
    .en      (shift_in_en),
    .load_en (1'b0),
    .load    ('0),
    .q       (in_q)
  );

  // Reply loaded at frame start, so the MSB is on miso before sclk rises
  spi_shift_reg shreg_out (
    .clk     (clk),
    .rst     (rst),
    .d       (1'b0),
    .en      (shift_out_en),
    .load_en (frame.pull_en),
    .load    (frame.pull_msg),
    .q       (out_q)
  );

  assign miso           = out_q[FRAME_BITS-1];
  assign frame.push_en  = cs_rise;
  assign frame.pull_en  = cs_fall;
  assign frame.push_msg = in_q;
  // Odd parity over bits 13:0 is an error, only meaningful in the push cycle
  assign frame.parity   = (^in_q[PAR_BIT:0]) & cs_rise;

endmodule

`default_nettype wire

// ==== reg_bridge.sv ====
// ----------------------------------------------------------------------
// Register bridge
// Decodes pushed SPI frames, keeps 32 eight-bit registers and holds
// the reply frame that the minion pulls at the next frame start
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module reg_bridge (
  input  logic        clk,
  input  logic        rst,
  spi_frame_if.bridge frame
);
  import spi_pkg::*;

  opcode_t                    op;
  logic [ADDR_MSB-ADDR_LSB:0] addr;
  logic [DATA_BITS-1:0]       wdata;
  logic [DATA_BITS-1:0]       rdata;
  status_t                    status;
  logic                       wr_en;
  frame_t                     reply_d;
  frame_t                     reply_q;

  logic [DATA_BITS-1:0] regs [NUM_REGS];

  // --------------------------------------------------------------------
  // Field decode
  // --------------------------------------------------------------------

  assign op    = opcode_t'(frame.push_msg[OP_MSB:OP_LSB]);
  assign addr  = frame.push_msg[ADDR_MSB:ADDR_LSB];
  assign wdata = frame.push_msg[DATA_BITS-1:0];

  // --------------------------------------------------------------------
  // Reply build
  // --------------------------------------------------------------------

  always_comb begin
    status = ST_IDLE;
    rdata  = '0;
    wr_en  = 1'b0;
    // Parity error overrides the opcode
    if (frame.parity) begin
      status = ST_PERR;
    end else begin
      case (op)
        OP_NOP: begin
          status = ST_IDLE;
        end
        OP_WRITE: begin
          status = ST_ACK;
          rdata  = wdata;
          wr_en  = frame.push_en;
        end
        OP_READ: begin
          status = ST_ACK;
          rdata  = regs[addr];
        end
        default: begin
          status = ST_BADOP;
        end
      endcase
    end

    // Bit 13 stays 0, address always echoed
    reply_d                    = '0;
    reply_d[OP_MSB:OP_LSB]     = status;
    reply_d[ADDR_MSB:ADDR_LSB] = addr;
    reply_d[DATA_BITS-1:0]     = rdata;
  end

  // --------------------------------------------------------------------
  // Register bank and reply register
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[addr] <= wdata;
    end
  end

  // Held between frames, read by the minion on its pull
  always_ff @(posedge clk) begin
    if (rst) begin
      reply_q <= '0;
    end else if (frame.push_en) begin
      reply_q <= reply_d;
    end
  end

  assign frame.pull_msg = reply_q;

endmodule

`default_nettype wire

// ==== spi_reg_top.sv ====
// ----------------------------------------------------------------------
// SPI register bridge top level
// SPI mode 0 minion joined to a 32-entry register bank
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spi_reg_top (
  input  logic clk,
  input  logic rst,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  // Push/pull link between minion and bridge
  spi_frame_if frame_if ();

  spi_minion u_minion (
    .clk   (clk),
    .rst   (rst),
    .cs    (cs),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso),
    .frame (frame_if.minion)
  );

  reg_bridge u_bridge (
    .clk   (clk),
    .rst   (rst),
    .frame (frame_if.bridge)
  );

endmodule

`default_nettype wire

// ==== tb_spi_reg_top.sv ====
// ----------------------------------------------------------------------
// Testbench for the SPI register bridge
// Acts as a mode 0 SPI host and replays command/reply vectors
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_spi_reg_top;
  import spi_pkg::*;

  localparam int MAX_VECS = 64;
  localparam int CS_GAP   = 10;

  logic   clk;
  logic   rst;
  logic   cs;
  logic   sclk;
  logic   mosi;
  logic   miso;
  frame_t vec_mem [0:2*MAX_VECS-1];
  integer seed = 32'h42f56e94;
  int     num_vecs;
  int     errors;
  int     failed;
  longint timeout_ns = 0;

  spi_reg_top UUT (
    .clk  (clk),
    .rst  (rst),
    .cs   (cs),
    .sclk (sclk),
    .mosi (mosi),
    .miso (miso)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Worst case sclk timing per vector plus margin
  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("sim failed");
    $finish;
  end

  // Pins move 1 ns after the clk edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // --------------------------------------------------------------------
  // SPI host, one 16-bit frame, MSB first
  // --------------------------------------------------------------------
  task automatic transfer_frame(input frame_t cmd, output frame_t rx);
    int half;
    rx = '0;
    cs = 1'b0;
    wait_cycles(4);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      mosi = cmd[i];
      half = 4 + ({$random(seed)} % 4);
      wait_cycles(half);
      // Reply bit taken as sclk rises
      rx[i] = miso;
      sclk  = 1'b1;
      half  = 4 + ({$random(seed)} % 4);
      wait_cycles(half);
      sclk = 1'b0;
    end
    wait_cycles(4);
    cs   = 1'b1;
    mosi = 1'b0;
    wait_cycles(CS_GAP);
  endtask

  task automatic check_reply(input string name, input frame_t exp, input frame_t act);
    if (act !== exp) begin
      $display("ERR %s: expected 0x%04h, got 0x%04h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("ERR %s: expected 0x%01h, got 0x%01h", name, exp, act);
      errors++;
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    frame_t cmd;
    frame_t exp_reply;
    frame_t rx;
    int     errs_before;
    rst      = 1'b1;
    cs       = 1'b1;
    sclk     = 1'b0;
    mosi     = 1'b0;
    errors   = 0;
    failed   = 0;
    num_vecs = 0;
    $readmemh("spi_vectors.txt", vec_mem);
    while (num_vecs < MAX_VECS && !$isunknown(vec_mem[2*num_vecs])) begin
      num_vecs++;
    end
    timeout_ns = longint'(num_vecs) * 16 * 2 * 7 * 4 + 2000;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    if (num_vecs == 0) begin
      $display("No vectors could be read from spi_vectors.txt");
      errors++;
    end
    for (int v = 0; v < num_vecs; v++) begin
      cmd         = vec_mem[2*v];
      exp_reply   = vec_mem[2*v+1];
      errs_before = errors;
      transfer_frame(cmd, rx);
      check_reply("miso reply", exp_reply, rx);
      check_status("reply status", status_t'(exp_reply[OP_MSB:OP_LSB]),
                   status_t'(rx[OP_MSB:OP_LSB]));
      if (errors == errs_before) begin
        $display("vector %0d: cmd 0x%04h reply 0x%04h ok", v, cmd, rx);
      end else begin
        failed++;
        $display("vector %0d: cmd 0x%04h reply 0x%04h mismatch", v, cmd, rx);
      end
    end
    $display("%0d vectors run, %0d passed, %0d failed, %0d errors",
             num_vecs, num_vecs - failed, failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
spi_pkg.sv
spi_frame_if.sv
spi_synchronizer.sv
spi_shift_reg.sv
spi_minion.sv
reg_bridge.sv
spi_reg_top.sv
tb_spi_reg_top.sv

// ==== spi_vectors.txt ====
// Column 1: command frame sent on mosi
// Column 2: reply expected on miso in the same frame (answer to the previous command)
0000 0000
433C 0000
8300 433C
// Write with a bad parity bit, then read back the old value
6377 433C
8300 8300
// Reserved opcode and NOP
C399 433C
8300 C300
0512 433C
// Address 0 and 31 with 00, FF, A5, 5A
40FF 0500
7F00 40FF
8000 5F00
BF00 40FF
40A5 5F00
7F5A 40A5
BF00 5F5A
8000 5F5A
4000 40A5
7FFF 4000
8000 5FFF
BF00 4000
8300 5FFF
70C3 433C
8000 50C3
B000 4000
9F00 50C3
0000 9F00
